//--- adc_capture.f
source/capture_pkg.sv
source/readout_pkg.sv
source/fifo_if.sv
source/sync_fifo.sv
source/capture_ctrl.sv
source/sample_packer.sv
source/byte_reader.sv
source/error_monitor.sv
source/adc_capture_top.sv
testbench/adc_capture_assert.sv
testbench/tb_adc_capture.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_adc_capture
FILELIST   ?= adc_capture.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only -Wall --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
FAIL_MSG   ?= Simulation FAILED
PASS_MSG   ?= Simulation PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "failure reported in $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "run ended without a result in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/tb_adc_capture.sv
module tb_adc_capture import capture_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [15:0]      pre;
        logic [15:0]      max;
        logic [3:0]       ds;
        logic             lo;
        logic             lsb;
        logic             clip;                 // ramp runs through both rails
        logic             noclip;
        logic             unf;                  // one read past empty
        logic [ERR_W-1:0] exp_err;
    } row_t;

    localparam int N_ROWS = 9;
    localparam row_t ROWS [N_ROWS] = '{
        '{16'd0,  16'd6,  4'd0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 6'h00},
        '{16'd0,  16'd9,  4'd0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 6'h00},
        '{16'd0,  16'd9,  4'd0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 6'h00},
        '{16'd12, 16'd24, 4'd0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 6'h00},
        '{16'd0,  16'd12, 4'd2, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 6'h00},
        '{16'd6,  16'd12, 4'd1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 6'h20},
        '{16'd0,  16'd6,  4'd0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 6'h10},
        '{16'd0,  16'd6,  4'd0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 6'h00},
        '{16'd0,  16'd6,  4'd0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 6'h00}
    };

    logic             adc_sampleclk;
    logic             reset;
    sample_t          adc_datain_i;
    logic             adc_capture_go_i;
    logic             arm_i;
    count_t           presample_i;
    count_t           max_samples_i;
    logic [DS_W-1:0]  downsample_i;
    logic             low_res_i;
    logic             low_res_lsb_i;
    logic             no_clip_errors_i;
    logic             clear_fifo_errors_i;
    logic             fifo_read_fifoen_i;
    logic             fifo_read_fifoempty_o;
    logic [7:0]       fifo_read_data_o;
    logic             adc_capture_stop_o;
    logic             error_flag_o;
    logic [ERR_W-1:0] error_stat_o;

    int               k;                        // rising edges since the arm edge
    logic [7:0]       exp_bytes [$];

    adc_capture_top i_adc_capture_top (.*);

    initial begin
        adc_sampleclk = 1'b0;
        forever #10 adc_sampleclk = ~adc_sampleclk;
    end

    function automatic int unsigned watchdog_cycles();
        int unsigned sum;
        sum = 0;
        for (int i = 0; i < N_ROWS; i++)
            sum += (ROWS[i].max + ROWS[i].pre) * (ROWS[i].ds + 1) * 4;
        return sum + 200 * N_ROWS;              // arm, trigger wait and readout margin
    endfunction

    task automatic step();
        @(negedge adc_sampleclk);
        adc_datain_i = adc_datain_i + 1'b1;     // ramp wraps at 4096
        k++;
    endtask

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        if (actual !== expected) begin
            $display("mismatch at time %0t: %s, got 0x%0h, expected 0x%0h",
                     $time, msg, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic arm_capture(input row_t row, input sample_t base);
        @(negedge adc_sampleclk);
        adc_datain_i     = base;
        k                = 0;                   // next rising edge is the arm edge
        arm_i            = 1'b1;
        presample_i      = row.pre;
        max_samples_i    = row.max;
        downsample_i     = DS_W'(row.ds);
        low_res_i        = row.lo;
        low_res_lsb_i    = row.lsb;
        no_clip_errors_i = row.noclip;
        step();
        arm_i = 1'b0;
        check(32'(adc_capture_stop_o), 0, "capture stop after arm");
        check(32'(fifo_read_fifoempty_o), 1, "empty flag after arm");
        check(32'(error_flag_o), 0, "error flag after arm");
    endtask

    // stream index pre is the trigger sample and neighbours are ds+1 ramp steps apart
    task automatic build_expected(input row_t row, input sample_t trig);
        int          total;
        sample_t     s [$];
        logic [71:0] grp;
        total = ((int'(row.max) + 2) / 3) * 3;
        exp_bytes.delete();
        for (int i = 0; i < total; i++)
            s.push_back(sample_t'(int'(trig) + (i - int'(row.pre)) * (int'(row.ds) + 1)));
        if (row.lo) begin
            foreach (s[i])
                exp_bytes.push_back(row.lsb ? s[i][7:0] : s[i][11:4]);
        end else begin
            for (int j = 0; j < total; j += 6) begin
                grp = {s[j], s[j+1], s[j+2], s[j+3], s[j+4], s[j+5]};   // oldest first
                for (int b = 0; b < 9; b++)
                    exp_bytes.push_back(grp[71-8*b -: 8]);
            end
        end
    endtask

    task automatic read_byte(output logic [7:0] data);
        while (fifo_read_fifoempty_o)
            step();
        data               = fifo_read_data_o;
        fifo_read_fifoen_i = 1'b1;
        step();
        fifo_read_fifoen_i = 1'b0;
    endtask

    task automatic run_row(input int idx, input row_t row);
        sample_t    base;
        sample_t    trig;
        int         g;
        int         t;
        int         total;
        logic [7:0] got;
        base = row.clip ? sample_t'(4089) : sample_t'(16 + ($urandom % 2048));
        arm_capture(row, base);
        g = (row.pre != 0) ? (int'(row.pre) + 2) * (int'(row.ds) + 1) + 2 : 3;
        while (k < g)
            step();
        adc_capture_go_i = 1'b1;                // seen at edge g
        t = (row.pre != 0) ? g : g + 1;
        while (t % (int'(row.ds) + 1) != 0)     // next write opportunity
            t++;
        trig  = base + sample_t'(t);
        total = ((int'(row.max) + 2) / 3) * 3;  // rounded up to whole words
        build_expected(row, trig);
        while (!adc_capture_stop_o)
            step();
        adc_capture_go_i = 1'b0;
        check(32'(k), 32'(t + (total - 1 - int'(row.pre)) * (int'(row.ds) + 1) + 1),
              $sformatf("row %0d edge of capture stop", idx));
        foreach (exp_bytes[i]) begin
            read_byte(got);
            check(32'(got), 32'(exp_bytes[i]), $sformatf("row %0d byte %0d", idx, i));
        end
        check(32'(fifo_read_fifoempty_o), 1, $sformatf("row %0d empty after readout", idx));
        check(32'(error_stat_o), 32'(row.exp_err), $sformatf("row %0d error_stat", idx));
        check(32'(error_flag_o), 32'(row.exp_err != '0), $sformatf("row %0d error_flag", idx));
        if (row.clip && !row.noclip) begin
            clear_fifo_errors_i = 1'b1;
            step();
            clear_fifo_errors_i = 1'b0;
            while (error_flag_o)
                step();
            check(32'(error_stat_o), 0, $sformatf("row %0d error_stat after clear", idx));
        end
        if (row.unf) begin
            fifo_read_fifoen_i = 1'b1;          // read while empty
            step();
            fifo_read_fifoen_i = 1'b0;
            while (!error_flag_o)
                step();
            check(32'(error_stat_o), 32'(1 << ERR_SLOW_UNF),
                  $sformatf("row %0d underflow", idx));
            repeat (4) begin
                check(32'(fifo_read_data_o), 0, $sformatf("row %0d data after underflow", idx));
                step();
            end
        end
    endtask

    initial begin
        int unsigned limit;
        limit = watchdog_cycles();
        repeat (limit) @(posedge adc_sampleclk);
        $display("timeout: the tests did not finish within %0d clock cycles", limit);
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(83));
        reset               = 1'b1;
        adc_datain_i        = '0;
        adc_capture_go_i    = 1'b0;
        arm_i               = 1'b0;
        presample_i         = '0;
        max_samples_i       = '0;
        downsample_i        = '0;
        low_res_i           = 1'b0;
        low_res_lsb_i       = 1'b0;
        no_clip_errors_i    = 1'b0;
        clear_fifo_errors_i = 1'b0;
        fifo_read_fifoen_i  = 1'b0;
        k                   = 0;
        repeat (4) @(negedge adc_sampleclk);
        reset = 1'b0;
        check(32'(adc_capture_stop_o), 0, "capture stop after reset");
        check(32'(error_flag_o), 0, "error flag after reset");
        check(32'(fifo_read_fifoempty_o), 1, "empty flag after reset");
        for (int i = 0; i < N_ROWS; i++)
            run_row(i, ROWS[i]);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- testbench/adc_capture_assert.sv
module adc_capture_assert import capture_pkg::*; (
    input logic             adc_sampleclk,
    input logic             reset,
    input logic             arm_pulse_i,
    input logic             fifo_empty_i,
    input logic             capture_stop_i,
    input logic             error_flag_i,
    input logic [ERR_W-1:0] error_stat_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // arm flushes both FIFOs in one cycle
    empty_after_arm: assert property (@(posedge adc_sampleclk) disable iff (reset)
        arm_pulse_i |=> fifo_empty_i)
        else $error("slow FIFO not empty in the cycle after arm");

    stop_held: assert property (@(posedge adc_sampleclk) disable iff (reset)
        capture_stop_i && !arm_pulse_i |=> capture_stop_i)   // only arm drops it
        else $error("capture stop fell without an arm");

    flag_with_status: assert property (@(posedge adc_sampleclk) disable iff (reset)
        $rose(error_flag_i) |-> (error_stat_i != '0))
        else $error("error flag rose with an empty status register");

endmodule

bind adc_capture_top adc_capture_assert i_adc_capture_assert (
    .adc_sampleclk  (adc_sampleclk),
    .reset          (reset),
    .arm_pulse_i    (arm_pulse),
    .fifo_empty_i   (fifo_read_fifoempty_o),
    .capture_stop_i (adc_capture_stop_o),
    .error_flag_i   (error_flag_o),
    .error_stat_i   (error_stat_o)
);

//--- source/adc_capture_top.sv
module adc_capture_top import capture_pkg::*; import readout_pkg::*; (
    input  logic             adc_sampleclk,
    input  logic             reset,
    input  sample_t          adc_datain_i,
    input  logic             adc_capture_go_i,
    input  logic             arm_i,
    input  count_t           presample_i,
    input  count_t           max_samples_i,
    input  logic [DS_W-1:0]  downsample_i,
    input  logic             low_res_i,
    input  logic             low_res_lsb_i,
    input  logic             no_clip_errors_i,
    input  logic             clear_fifo_errors_i,
    input  logic             fifo_read_fifoen_i,
    output logic             fifo_read_fifoempty_o,
    output logic [7:0]       fifo_read_data_o,
    output logic             adc_capture_stop_o,
    output logic             error_flag_o,
    output logic [ERR_W-1:0] error_stat_o
);

    fifo_if #(.T(sample_t)) fast_if ();        // raw samples
    fifo_if #(.T(word_t))   slow_if ();        // packed words

    logic arm_pulse;
    logic drain;
    logic pack_en;
    logic pack_busy;
    logic presamp_err;
    logic downsample_err;
    logic unf_sticky;

    assign fifo_read_fifoempty_o = slow_if.empty;

    sync_fifo #(.T(sample_t), .DEPTH(FAST_DEPTH)) i_fast_fifo (
        .adc_sampleclk, .reset, .flush_i(arm_pulse), .f(fast_if.mem)
    );

    sync_fifo #(.T(word_t), .DEPTH(SLOW_DEPTH)) i_slow_fifo (
        .adc_sampleclk, .reset, .flush_i(arm_pulse), .f(slow_if.mem)
    );

    capture_ctrl i_capture_ctrl (
        .adc_sampleclk, .reset, .arm_i, .adc_capture_go_i,
        .adc_data_i       (adc_datain_i),
        .presample_i, .max_samples_i, .downsample_i,
        .fast_empty_i     (fast_if.empty),
        .busy_i           (pack_busy),
        .arm_pulse_o      (arm_pulse),
        .capture_stop_o   (adc_capture_stop_o),
        .presamp_err_o    (presamp_err),
        .downsample_err_o (downsample_err),
        .drain_o          (drain),
        .pack_en_o        (pack_en),
        .fast_wr          (fast_if.writer)
    );

    sample_packer i_sample_packer (
        .adc_sampleclk, .reset,
        .arm_pulse_i (arm_pulse),
        .drain_i     (drain),
        .pack_en_i   (pack_en),
        .fast_rd     (fast_if.reader),
        .slow_wr     (slow_if.writer),
        .busy_o      (pack_busy)
    );

    byte_reader i_byte_reader (
        .adc_sampleclk, .reset, .low_res_i, .low_res_lsb_i,
        .arm_pulse_i  (arm_pulse),
        .fifoen_i     (fifo_read_fifoen_i),
        .slow_rd      (slow_if.reader),
        .data_o       (fifo_read_data_o),
        .unf_sticky_o (unf_sticky)
    );

    error_monitor i_error_monitor (
        .adc_sampleclk, .reset, .no_clip_errors_i, .error_flag_o, .error_stat_o,
        .arm_pulse_i      (arm_pulse),
        .clear_i          (clear_fifo_errors_i),
        .adc_data_i       (adc_datain_i),
        .fast_wr_i        (fast_if.wr_en),
        .downsample_err_i (downsample_err),
        .presamp_err_i    (presamp_err),
        .fast_ovf_i       (fast_if.overflow),
        .slow_ovf_i       (slow_if.overflow),
        .slow_unf_i       (unf_sticky)      // underflow holds until re-arm
    );

endmodule

//--- source/error_monitor.sv
module error_monitor import capture_pkg::*; (
    input  logic             adc_sampleclk,
    input  logic             reset,
    input  logic             arm_pulse_i,
    input  logic             clear_i,
    input  logic             no_clip_errors_i,
    input  sample_t          adc_data_i,
    input  logic             fast_wr_i,
    input  logic             downsample_err_i,
    input  logic             presamp_err_i,
    input  logic             fast_ovf_i,
    input  logic             slow_ovf_i,
    input  logic             slow_unf_i,
    output logic             error_flag_o,
    output logic [ERR_W-1:0] error_stat_o
);

    logic             clip_err;
    logic [ERR_W-1:0] err_vec;

    // a written sample at either rail counts as clipped
    assign clip_err = !no_clip_errors_i && fast_wr_i
                      && ((adc_data_i == '1) || (adc_data_i == '0));

    always_comb begin
        err_vec                 = '0;
        err_vec[ERR_DOWNSAMPLE] = downsample_err_i;
        err_vec[ERR_CLIP]       = clip_err;
        err_vec[ERR_PRESAMP]    = presamp_err_i;
        err_vec[ERR_FAST_OVF]   = fast_ovf_i;
        err_vec[ERR_SLOW_OVF]   = slow_ovf_i;
        err_vec[ERR_SLOW_UNF]   = slow_unf_i;
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset || arm_pulse_i || clear_i) begin
            error_flag_o <= 1'b0;
            error_stat_o <= '0;
        end else if (|err_vec) begin
            error_flag_o <= 1'b1;
            error_stat_o <= error_stat_o | err_vec;   // bits stay set until arm or clear
        end
    end

endmodule

//--- source/byte_reader.sv
module byte_reader import capture_pkg::*; import readout_pkg::*; (
    input  logic       adc_sampleclk,
    input  logic       reset,
    input  logic       arm_pulse_i,
    input  logic       low_res_i,
    input  logic       low_res_lsb_i,
    input  logic       fifoen_i,
    fifo_if.reader     slow_rd,
    output logic [7:0] data_o,
    output logic       unf_sticky_o
);

    lane_t      lane;
    lane_t      last_lane;
    logic       pop_lane;
    logic [3:0] nib_q;                          // low nibble of first word, for lane 4
    sample_t    lo_sample;

    assign last_lane = low_res_i ? lane_t'(LO_RES_LANES - 1) : lane_t'(HI_RES_LANES - 1);
    assign pop_lane  = (lane == last_lane) || (!low_res_i && (lane == lane_t'(3)));

    // any read while empty also reaches the FIFO so it reports underflow
    assign slow_rd.rd_en = fifoen_i && (pop_lane || slow_rd.empty);

    always_ff @(posedge adc_sampleclk) begin
        if (reset || arm_pulse_i) begin
            lane         <= '0;
            unf_sticky_o <= 1'b0;
        end else begin
            if (fifoen_i)
                lane <= (lane >= last_lane) ? lane_t'(0) : lane + 1'b1;
            if (slow_rd.underflow)
                unf_sticky_o <= 1'b1;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (fifoen_i && !low_res_i && (lane == lane_t'(3)))
            nib_q <= slow_rd.dout[3:0];
    end

    always_comb begin
        case (lane[1:0])
            2'd0:    lo_sample = slow_rd.dout[3*SAMPLE_W-1 -: SAMPLE_W];
            2'd1:    lo_sample = slow_rd.dout[2*SAMPLE_W-1 -: SAMPLE_W];
            default: lo_sample = slow_rd.dout[SAMPLE_W-1:0];
        endcase

        if (unf_sticky_o) begin
            data_o = 8'h00;
        end else if (low_res_i) begin
            data_o = low_res_lsb_i ? lo_sample[7:0] : lo_sample[SAMPLE_W-1 -: 8];
        end else begin
            case (lane)                         // two words give nine bytes
                4'd0:    data_o = slow_rd.dout[35:28];
                4'd1:    data_o = slow_rd.dout[27:20];
                4'd2:    data_o = slow_rd.dout[19:12];
                4'd3:    data_o = slow_rd.dout[11:4];
                4'd4:    data_o = {nib_q, slow_rd.dout[35:32]};
                4'd5:    data_o = slow_rd.dout[31:24];
                4'd6:    data_o = slow_rd.dout[23:16];
                4'd7:    data_o = slow_rd.dout[15:8];
                4'd8:    data_o = slow_rd.dout[7:0];
                default: data_o = 8'h00;
            endcase
        end
    end

endmodule

//--- source/sample_packer.sv
module sample_packer import capture_pkg::*; import readout_pkg::*; (
    input  logic   adc_sampleclk,
    input  logic   reset,
    input  logic   arm_pulse_i,
    input  logic   drain_i,
    input  logic   pack_en_i,
    fifo_if.reader fast_rd,
    fifo_if.writer slow_wr,
    output logic   busy_o
);

    word_t      word_q;
    logic [1:0] fill;                           // samples held in word_q
    logic       pop;
    logic       wr_q;

    assign pop           = pack_en_i && !drain_i && !fast_rd.empty && !slow_wr.full;
    assign fast_rd.rd_en = drain_i || pop;      // drained samples are discarded
    assign slow_wr.wr_en = wr_q;
    assign slow_wr.din   = word_q;
    assign busy_o        = (fill != 2'd0) || wr_q;

    always_ff @(posedge adc_sampleclk) begin
        if (reset || arm_pulse_i) begin
            fill <= 2'd0;
            wr_q <= 1'b0;
        end else begin
            wr_q <= pop && (fill == 2'(SAMPLES_PER_WORD - 1));   // word out the cycle after
            if (pop)
                fill <= (fill == 2'(SAMPLES_PER_WORD - 1)) ? 2'd0 : fill + 2'd1;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (pop)
            word_q <= {word_q[WORD_W-SAMPLE_W-1:0], fast_rd.dout};
    end

endmodule

//--- source/capture_ctrl.sv
module capture_ctrl import capture_pkg::*; (
    input  logic            adc_sampleclk,
    input  logic            reset,
    input  logic            arm_i,
    input  logic            adc_capture_go_i,
    input  sample_t         adc_data_i,
    input  count_t          presample_i,
    input  count_t          max_samples_i,
    input  logic [DS_W-1:0] downsample_i,
    input  logic            fast_empty_i,
    input  logic            busy_i,
    output logic            arm_pulse_o,
    output logic            capture_stop_o,
    output logic            presamp_err_o,
    output logic            downsample_err_o,
    output logic            drain_o,
    output logic            pack_en_o,
    fifo_if.writer          fast_wr
);

    capture_state_t  state;
    logic            arm_r;
    logic            armed;
    logic [DS_W-1:0] ds_cnt;
    logic            ds_tick;
    logic            wr;
    count_t          sample_cnt;
    count_t          sample_cnt_nxt;
    logic [1:0]      phase;
    logic [1:0]      phase_nxt;
    logic            last_wr;

    assign arm_pulse_o    = arm_i && !arm_r;
    assign ds_tick        = (ds_cnt >= downsample_i);     // one opportunity per downsample_i+1
    assign wr             = ds_tick && (state inside {PRESAMP_FILLING, PRESAMP_FULL, TRIGGERED});
    assign drain_o        = wr && (state == PRESAMP_FULL) && !adc_capture_go_i;
    assign presamp_err_o  = (state == PRESAMP_FILLING) && adc_capture_go_i;
    assign pack_en_o      = (state == TRIGGERED) || (state == DONE);
    assign sample_cnt_nxt = sample_cnt + 1'b1;
    assign phase_nxt      = (phase == 2'd2) ? 2'd0 : phase + 2'd1;   // stream index mod 3

    // stop once max is reached on a word boundary
    assign last_wr = wr && (state == TRIGGERED) && (sample_cnt_nxt >= max_samples_i)
                     && (phase_nxt == 2'd0);

    assign fast_wr.wr_en = wr;
    assign fast_wr.din   = adc_data_i;

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            arm_r  <= 1'b0;
            ds_cnt <= '0;
        end else begin
            arm_r <= arm_i;
            if (arm_pulse_o || ds_tick)
                ds_cnt <= '0;
            else
                ds_cnt <= ds_cnt + 1'b1;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            state            <= IDLE;
            armed            <= 1'b0;
            sample_cnt       <= '0;
            phase            <= '0;
            capture_stop_o   <= 1'b0;
            downsample_err_o <= 1'b0;
        end else if (arm_pulse_o) begin
            state            <= IDLE;
            armed            <= 1'b1;
            sample_cnt       <= '0;
            phase            <= '0;
            capture_stop_o   <= 1'b0;
            downsample_err_o <= 1'b0;
        end else begin
            if (wr && !drain_o) begin           // drained writes keep the count at presample_i
                sample_cnt <= sample_cnt_nxt;
                phase      <= phase_nxt;
            end
            case (state)
                IDLE: begin
                    downsample_err_o <= (downsample_i != '0) && (presample_i != '0);
                    if (armed && (presample_i != '0)) begin
                        armed <= 1'b0;
                        state <= PRESAMP_FILLING;
                    end else if (armed && adc_capture_go_i) begin
                        armed <= 1'b0;
                        state <= TRIGGERED;
                    end
                end
                PRESAMP_FILLING: begin
                    if (adc_capture_go_i)
                        state <= TRIGGERED;     // early trigger, flagged as presample error
                    else if (wr && (sample_cnt_nxt >= presample_i))
                        state <= PRESAMP_FULL;
                end
                PRESAMP_FULL: begin
                    if (adc_capture_go_i)
                        state <= TRIGGERED;
                end
                TRIGGERED: begin
                    if (last_wr) begin
                        capture_stop_o <= 1'b1; // held until next arm
                        state          <= DONE;
                    end
                end
                DONE: begin
                    if (fast_empty_i && !busy_i)
                        state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- source/sync_fifo.sv
module sync_fifo import capture_pkg::*; #(
    parameter type T     = sample_t,
    parameter int  DEPTH = FAST_DEPTH
) (
    input  logic adc_sampleclk,
    input  logic reset,
    input  logic flush_i,
    fifo_if.mem  f
);

    localparam int AW = $clog2(DEPTH);

    T              mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_wr;
    logic          do_rd;

    assign f.full  = (count == (AW+1)'(DEPTH));
    assign f.empty = (count == '0);
    assign f.dout  = mem[rd_ptr];               // show-ahead
    assign do_wr   = f.wr_en && !f.full;        // write on full is dropped
    assign do_rd   = f.rd_en && !f.empty;

    always_ff @(posedge adc_sampleclk) begin
        if (reset || flush_i) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            f.overflow  <= 1'b0;
            f.underflow <= 1'b0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;        // depth is a power of two
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            count       <= count + (AW+1)'(do_wr) - (AW+1)'(do_rd);
            f.overflow  <= f.wr_en && f.full;
            f.underflow <= f.rd_en && f.empty;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (do_wr)
            mem[wr_ptr] <= f.din;
    end

endmodule

//--- source/fifo_if.sv
interface fifo_if #(
    parameter type T = logic
);

    logic wr_en;
    T     din;
    logic rd_en;
    T     dout;                                 // head entry, valid while !empty
    logic full;
    logic empty;
    logic overflow;                             // one-cycle pulses
    logic underflow;

    modport mem    (input wr_en, din, rd_en, output dout, full, empty, overflow, underflow);
    modport writer (output wr_en, din, input full, overflow);
    modport reader (output rd_en, input dout, empty, underflow);

endinterface

//--- source/readout_pkg.sv
package readout_pkg;

    import capture_pkg::*;

    localparam int SAMPLES_PER_WORD = 3;
    localparam int WORD_W = SAMPLES_PER_WORD * SAMPLE_W;

    // oldest sample sits in the top bits
    typedef logic [WORD_W-1:0] word_t;

    localparam int HI_RES_LANES = 9;            // bytes per two words
    localparam int LO_RES_LANES = 3;            // bytes per word

    typedef logic [3:0] lane_t;

endpackage

//--- source/capture_pkg.sv
package capture_pkg;

    localparam int SAMPLE_W = 12;
    typedef logic [SAMPLE_W-1:0] sample_t;

    localparam int CNT_W = 16;
    typedef logic [CNT_W-1:0] count_t;

    localparam int DS_W = 13;                   // downsample factor width

    localparam int FAST_DEPTH = 64;             // presample setting valid up to 48
    localparam int SLOW_DEPTH = 32;             // in packed words

    typedef enum logic [2:0] {
        IDLE,
        PRESAMP_FILLING,
        PRESAMP_FULL,
        TRIGGERED,
        DONE
    } capture_state_t;

    localparam int ERR_W          = 6;
    localparam int ERR_DOWNSAMPLE = 5;
    localparam int ERR_CLIP       = 4;
    localparam int ERR_PRESAMP    = 3;
    localparam int ERR_FAST_OVF   = 2;
    localparam int ERR_SLOW_OVF   = 1;
    localparam int ERR_SLOW_UNF   = 0;

endpackage
